// ==== robot_settings.svh ====
`ifndef ROBOT_SETTINGS_SVH
`define ROBOT_SETTINGS_SVH

//////////////////////////////////////////////////
// IR line timing
//////////////////////////////////////////////////

// Clocks per IR time unit, short for simulation
`define IR_UNIT 8

// Mark and space lengths in units
`define IR_START_UNITS 4
`define IR_ONE_UNITS 2
`define IR_ZERO_UNITS 1
`define IR_SPACE_UNITS 1

// Slack in clocks when matching a mark
`define IR_TOL 2

//////////////////////////////////////////////////
// Motor drive timing
//////////////////////////////////////////////////

// Clocks per PWM period
`define PWM_PERIOD 32

// PWM periods per duration count
`define DUR_STEP 2

`endif

// ==== robot_pkg.sv ====
package robot_pkg;

   //////////////////////////////////////////////////
   // Configuration opcodes
   //////////////////////////////////////////////////

   // Remaining codes are ignored by the controller
   typedef enum logic [2:0] {
      CFG_STOP      = 3'd0,
      CFG_SPEED_CAP = 3'd1
   } cfg_op_e;

   //////////////////////////////////////////////////
   // Move word, 12 bits
   //////////////////////////////////////////////////

   // Top bit picks the view
   // kind 0 means drive, kind 1 means config
   typedef union packed {
      // Wheel directions, speed and run time
      struct packed {
         logic       kind;
         logic       left_rev;
         logic       right_rev;
         logic [4:0] speed;
         // Zero keeps the drive running
         logic [3:0] duration;
      } drive;
      // Stop or speed cap
      struct packed {
         logic       kind;
         cfg_op_e    opcode;
         // Cap uses the low 5 bits only
         logic [7:0] value;
      } cfg;
   } move_cmd_u;

endpackage

// ==== ir_receiver.sv ====
`include "robot_settings.svh"

module ir_receiver (
   input  logic                 clk100_mhz,
   input  logic                 arst_n,
   input  logic                 ir_in,
   output robot_pkg::move_cmd_u move_word,
   output logic                 done,
   output logic [7:0]           frame_errors
);

   // Nominal lengths in clocks
   localparam int START_LEN = `IR_START_UNITS * `IR_UNIT;
   localparam int ONE_LEN   = `IR_ONE_UNITS * `IR_UNIT;
   localparam int ZERO_LEN  = `IR_ZERO_UNITS * `IR_UNIT;
   // Longest space still inside a frame
   localparam int SPACE_MAX = 2 * `IR_SPACE_UNITS * `IR_UNIT;
   localparam int FRAME_BITS = 12;

   // FSM encoding
   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_START = 2'd1;
   localparam logic [1:0] ST_BITS  = 2'd2;

   logic        ir_s1;
   logic        ir_s2;
   logic        ir_prev;
   logic [7:0]  run_len;
   logic [1:0]  state;
   logic [3:0]  bit_cnt;
   logic [10:0] shreg;
   logic        mark_start;
   logic        mark_end;
   logic        space_long;
   logic        is_start;
   logic        is_one;
   logic        is_zero;
   logic        frame_err;

   // Length within tolerance of a nominal value
   function automatic logic in_window(input logic [7:0] len, input int nominal);
      return (int'(len) >= nominal - `IR_TOL) && (int'(len) <= nominal + `IR_TOL);
   endfunction

   //////////////////////////////////////////////////
   // Input sync and run-length timing
   //////////////////////////////////////////////////

   // Line idles high
   always_ff @(posedge clk100_mhz or negedge arst_n) begin
      if (!arst_n) begin
         ir_s1   <= 1'b1;
         ir_s2   <= 1'b1;
         ir_prev <= 1'b1;
      end else begin
         ir_s1   <= ir_in;
         ir_s2   <= ir_s1;
         ir_prev <= ir_s2;
      end
   end

   // On an edge run_len holds the length of the level just ended
   always_ff @(posedge clk100_mhz or negedge arst_n) begin
      if (!arst_n) begin
         run_len <= '0;
      end else if (ir_s2 != ir_prev) begin
         run_len <= 8'd1;
      end else if (run_len != 8'hff) begin
         run_len <= run_len + 8'd1;
      end
   end

   assign mark_start = ir_prev && !ir_s2;
   assign mark_end   = !ir_prev && ir_s2;
   assign space_long = ir_prev && ir_s2 && (run_len > 8'(SPACE_MAX));

   // Mark classes
   assign is_start = in_window(run_len, START_LEN);
   assign is_one   = in_window(run_len, ONE_LEN);
   assign is_zero  = in_window(run_len, ZERO_LEN);

   // Bad mark inside a frame, or a frame that stalls
   assign frame_err = (mark_end && (state != ST_IDLE) && !(is_start || is_one || is_zero))
                    || ((state == ST_BITS) && space_long);

   //////////////////////////////////////////////////
   // Frame FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk100_mhz or negedge arst_n) begin
      if (!arst_n) begin
         state        <= ST_IDLE;
         bit_cnt      <= '0;
         done         <= 1'b0;
         move_word    <= '0;
         frame_errors <= '0;
      end else begin
         done <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (mark_start) begin
                  state <= ST_START;
               end
            end
            ST_START: begin
               // Stray bit marks drop back quietly
               if (mark_end) begin
                  state   <= is_start ? ST_BITS : ST_IDLE;
                  bit_cnt <= '0;
               end
            end
            ST_BITS: begin
               if (mark_end) begin
                  if (is_start) begin
                     // Fresh start mark, resync
                     bit_cnt <= '0;
                  end else if (is_one || is_zero) begin
                     if (bit_cnt == 4'(FRAME_BITS - 1)) begin
                        done      <= 1'b1;
                        move_word <= {is_one, shreg};
                        state     <= ST_IDLE;
                     end else begin
                        bit_cnt <= bit_cnt + 4'd1;
                     end
                  end else begin
                     state <= ST_IDLE;
                  end
               end else if (space_long) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
         // Saturating error count
         if (frame_err && (frame_errors != 8'hff)) begin
            frame_errors <= frame_errors + 8'd1;
         end
      end
   end

   // LSB arrives first, shifts toward bit 0
   always_ff @(posedge clk100_mhz) begin
      if ((state == ST_BITS) && mark_end && (is_one || is_zero)) begin
         shreg <= {is_one, shreg[10:1]};
      end
   end

   // Strobe for one cycle only
   assert property (@(posedge clk100_mhz) disable iff (!arst_n) done |=> !done);

endmodule

// ==== move_controller.sv ====
`include "robot_settings.svh"

module move_controller (
   input  logic                 clk100_mhz,
   input  logic                 arst_n,
   input  robot_pkg::move_cmd_u move_word,
   input  logic                 done,
   input  logic                 period_start,
   output logic [4:0]           duty_l,
   output logic [4:0]           duty_r,
   output logic                 rev_l,
   output logic                 rev_r,
   output logic                 busy,
   output robot_pkg::move_cmd_u last_word
);
   import robot_pkg::*;

   // Longest timed drive in periods
   localparam int LEFT_MAX = 15 * `DUR_STEP;
   localparam int LEFT_W   = $clog2(LEFT_MAX + 1);

   move_cmd_u         pend_word;
   logic              pend_valid;
   logic [4:0]        cap;
   logic [4:0]        run_speed;
   logic [4:0]        duty;
   logic              timed;
   logic [LEFT_W-1:0] periods_left;
   logic              is_drive;
   logic              is_stop;
   logic              is_cap;

   function automatic logic [4:0] clamp(input logic [4:0] speed, input logic [4:0] limit);
      return (speed < limit) ? speed : limit;
   endfunction

   // Decode by kind bit
   assign is_drive = done && !move_word.drive.kind;
   assign is_stop  = done && move_word.cfg.kind && (move_word.cfg.opcode == CFG_STOP);
   assign is_cap   = done && move_word.cfg.kind && (move_word.cfg.opcode == CFG_SPEED_CAP);

   // Both wheels share one speed
   assign duty_l = duty;
   assign duty_r = duty;

   //////////////////////////////////////////////////
   // Drive sequencing
   //////////////////////////////////////////////////

   always_ff @(posedge clk100_mhz or negedge arst_n) begin
      if (!arst_n) begin
         pend_valid   <= 1'b0;
         cap          <= 5'd31;
         run_speed    <= '0;
         duty         <= '0;
         rev_l        <= 1'b0;
         rev_r        <= 1'b0;
         busy         <= 1'b0;
         timed        <= 1'b0;
         periods_left <= '0;
         last_word    <= '0;
      end else begin
         if (period_start) begin
            if (pend_valid) begin
               // Start or replace the drive
               pend_valid   <= 1'b0;
               run_speed    <= pend_word.drive.speed;
               duty         <= clamp(pend_word.drive.speed, cap);
               rev_l        <= pend_word.drive.left_rev;
               rev_r        <= pend_word.drive.right_rev;
               busy         <= 1'b1;
               timed        <= (pend_word.drive.duration != 4'd0);
               periods_left <= LEFT_W'(int'(pend_word.drive.duration) * `DUR_STEP);
            end else if (busy) begin
               if (timed && (periods_left == LEFT_W'(1))) begin
                  // Last period done
                  duty <= '0;
                  busy <= 1'b0;
               end else begin
                  // Cap changes land here
                  duty <= clamp(run_speed, cap);
                  if (timed) begin
                     periods_left <= periods_left - LEFT_W'(1);
                  end
               end
            end
         end
         // New words win over the boundary update
         if (done) begin
            last_word <= move_word;
         end
         if (is_drive) begin
            pend_valid <= 1'b1;
         end
         if (is_cap) begin
            cap <= move_word.cfg.value[4:0];
         end
         if (is_stop) begin
            pend_valid <= 1'b0;
            duty       <= '0;
            busy       <= 1'b0;
         end
      end
   end

   // Held drive word
   always_ff @(posedge clk100_mhz) begin
      if (is_drive) begin
         pend_word <= move_word;
      end
   end

   // Duty set at a boundary stays under the cap in force there
   assert property (@(posedge clk100_mhz) disable iff (!arst_n)
      period_start |=> (duty <= $past(cap)));

   // Motors spin up only through a pending drive
   assert property (@(posedge clk100_mhz) disable iff (!arst_n)
      (!busy && !pend_valid) |=> (duty == 5'd0));

endmodule

// ==== motor_pwm.sv ====
`include "robot_settings.svh"

module motor_pwm (
   input  logic       clk100_mhz,
   input  logic       arst_n,
   input  logic [4:0] duty,
   input  logic       rev,
   output logic       motor,
   output logic       dir,
   output logic       period_start
);

   localparam int CNT_W = $clog2(`PWM_PERIOD);
   localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`PWM_PERIOD - 1);
   // Quiet cycles between two wraps
   localparam int GAP = `PWM_PERIOD - 1;

   logic [CNT_W-1:0] cnt;

   //////////////////////////////////////////////////
   // Period counter
   //////////////////////////////////////////////////

   always_ff @(posedge clk100_mhz or negedge arst_n) begin
      if (!arst_n) begin
         cnt <= '0;
      end else if (cnt == CNT_LAST) begin
         cnt <= '0;
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   // Controller updates duty on this edge
   assign period_start = (cnt == CNT_LAST);

   //////////////////////////////////////////////////
   // Compare and direction
   //////////////////////////////////////////////////

   // High for duty counts, one clock behind the counter
   always_ff @(posedge clk100_mhz or negedge arst_n) begin
      if (!arst_n) begin
         motor <= 1'b0;
         dir   <= 1'b0;
      end else begin
         motor <= (int'(cnt) < int'(duty));
         // Taken with the first compare of a period
         if (cnt == '0) begin
            dir <= rev;
         end
      end
   end

   // Wrap pulse is strictly periodic
   assert property (@(posedge clk100_mhz) disable iff (!arst_n)
      period_start |=> (!period_start) [*GAP] ##1 period_start);

endmodule

// ==== robot_top.sv ====
module robot_top (
   input  logic                 clk100_mhz,
   input  logic                 arst_n,
   input  logic                 ir_in,
   output logic                 motor_l,
   output logic                 motor_r,
   output logic                 dir_l,
   output logic                 dir_r,
   output logic                 busy,
   output robot_pkg::move_cmd_u last_word,
   output logic [7:0]           frame_errors
);
   import robot_pkg::*;

   // Receiver to controller
   move_cmd_u  move_word;
   logic       word_done;
   // Controller to motors
   logic [4:0] duty_l;
   logic [4:0] duty_r;
   logic       rev_l;
   logic       rev_r;
   // Left channel paces the controller
   logic       period_start;

   //////////////////////////////////////////////////
   // IR front end and control
   //////////////////////////////////////////////////

   ir_receiver ir_receiver_inst (
      .clk100_mhz   (clk100_mhz),
      .arst_n       (arst_n),
      .ir_in        (ir_in),
      .move_word    (move_word),
      .done         (word_done),
      .frame_errors (frame_errors)
   );

   move_controller move_controller_inst (
      .clk100_mhz   (clk100_mhz),
      .arst_n       (arst_n),
      .move_word    (move_word),
      .done         (word_done),
      .period_start (period_start),
      .duty_l       (duty_l),
      .duty_r       (duty_r),
      .rev_l        (rev_l),
      .rev_r        (rev_r),
      .busy         (busy),
      .last_word    (last_word)
   );

   //////////////////////////////////////////////////
   // Motor channels
   //////////////////////////////////////////////////

   motor_pwm left (
      .clk100_mhz   (clk100_mhz),
      .arst_n       (arst_n),
      .duty         (duty_l),
      .rev          (rev_l),
      .motor        (motor_l),
      .dir          (dir_l),
      .period_start (period_start)
   );

   // Same reset and clock, so in phase with the left one
   motor_pwm right (
      .clk100_mhz   (clk100_mhz),
      .arst_n       (arst_n),
      .duty         (duty_r),
      .rev          (rev_r),
      .motor        (motor_r),
      .dir          (dir_r),
      .period_start ()
   );

endmodule

// ==== tb_robot.sv ====
`include "robot_settings.svh"

module tb_robot;
   timeunit 1ns;
   timeprecision 100ps;
   import robot_pkg::*;

   localparam int CLK_PERIOD = 10;
   localparam int UNIT       = `IR_UNIT;
   localparam int PER        = `PWM_PERIOD;

   logic       clk100_mhz;
   logic       arst_n;
   logic       ir_in;
   logic       motor_l;
   logic       motor_r;
   logic       dir_l;
   logic       dir_r;
   logic       busy;
   move_cmd_u  last_word;
   logic [7:0] frame_errors;

   int          errors;
   int          timeouts;
   logic [31:0] rng;
   // Model state
   int          pwm_phase;
   logic [4:0]  model_cap;
   logic [11:0] exp_last;

   robot_top robot_top_inst (
      .clk100_mhz   (clk100_mhz),
      .arst_n       (arst_n),
      .ir_in        (ir_in),
      .motor_l      (motor_l),
      .motor_r      (motor_r),
      .dir_l        (dir_l),
      .dir_r        (dir_r),
      .busy         (busy),
      .last_word    (last_word),
      .frame_errors (frame_errors)
   );

   always #(CLK_PERIOD / 2) clk100_mhz = ~clk100_mhz;

   // PWM period model, free running from reset
   always @(posedge clk100_mhz or negedge arst_n) begin
      if (!arst_n) begin
         pwm_phase <= 0;
      end else begin
         pwm_phase <= (pwm_phase == PER - 1) ? 0 : pwm_phase + 1;
      end
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [11:0] drive_word(input logic lrev, input logic rrev,
                                              input logic [4:0] speed, input logic [3:0] dur);
      move_cmd_u u;
      u.drive.kind      = 1'b0;
      u.drive.left_rev  = lrev;
      u.drive.right_rev = rrev;
      u.drive.speed     = speed;
      u.drive.duration  = dur;
      return u;
   endfunction

   function automatic logic [11:0] cfg_word(input cfg_op_e op, input logic [7:0] value);
      move_cmd_u u;
      u.cfg.kind   = 1'b1;
      u.cfg.opcode = op;
      u.cfg.value  = value;
      return u;
   endfunction

   // Word must differ from the last one so its arrival shows
   function automatic logic [11:0] unlike_last(input logic [11:0] w, input logic [11:0] last);
      return (w == last) ? (w ^ 12'h020) : w;
   endfunction

   task automatic roll(output logic [31:0] r);
      rng = xorshift32(rng);
      r   = rng;
   endtask

   // All stimulus and sampling sit 1 ns after the edge
   task automatic tick();
      @(posedge clk100_mhz);
      #1;
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic note_timeout(input string what);
      $display("timeout at %0t while waiting for %s", $time, what);
      timeouts++;
   endtask

   //////////////////////////////////////////////////
   // IR frame driver
   //////////////////////////////////////////////////

   task automatic hold_level(input logic level, input int clocks);
      ir_in = level;
      repeat (clocks) tick();
   endtask

   // Start mark, then 12 bits LSB first, line left idle
   task automatic send_frame(input logic [11:0] w);
      hold_level(1'b0, `IR_START_UNITS * UNIT);
      hold_level(1'b1, `IR_SPACE_UNITS * UNIT);
      for (int i = 0; i < 12; i++) begin
         hold_level(1'b0, (w[i] ? `IR_ONE_UNITS : `IR_ZERO_UNITS) * UNIT);
         if (i < 11) begin
            hold_level(1'b1, `IR_SPACE_UNITS * UNIT);
         end
      end
      ir_in = 1'b1;
   endtask

   // Three zero bits, then a mark between the one and start lengths
   task automatic send_bad_frame();
      hold_level(1'b0, `IR_START_UNITS * UNIT);
      hold_level(1'b1, `IR_SPACE_UNITS * UNIT);
      repeat (3) begin
         hold_level(1'b0, `IR_ZERO_UNITS * UNIT);
         hold_level(1'b1, `IR_SPACE_UNITS * UNIT);
      end
      hold_level(1'b0, 3 * UNIT);
      ir_in = 1'b1;
   endtask

   // Send and wait for last_word to move, model tracks the cap
   task automatic deliver(input logic [11:0] w);
      move_cmd_u u;
      int n;
      u = w;
      n = 0;
      send_frame(w);
      while ((last_word == exp_last) && (n < 16)) begin
         tick();
         n++;
      end
      if (last_word == exp_last) begin
         note_timeout("a decoded move word");
      end
      check("last_word", last_word, w);
      exp_last = w;
      if (u.cfg.kind && (u.cfg.opcode == CFG_SPEED_CAP)) begin
         model_cap = u.cfg.value[4:0];
      end
   endtask

   //////////////////////////////////////////////////
   // PWM observation
   //////////////////////////////////////////////////

   // Stops on the first sample of a new period
   task automatic wait_period_start();
      int n;
      n = 0;
      tick();
      while ((pwm_phase != 0) && (n < PER + 4)) begin
         tick();
         n++;
      end
      if (pwm_phase != 0) begin
         note_timeout("a PWM period boundary");
      end
   endtask

   // Output lags the counter by one, so the window runs phase 1 to 0
   task automatic measure_period(output int high_l, output int high_r);
      high_l = 0;
      high_r = 0;
      repeat (PER) begin
         tick();
         if (motor_l) high_l++;
         if (motor_r) high_r++;
      end
   endtask

   task automatic check_duty(input logic [4:0] speed);
      int hl;
      int hr;
      int exp_high;
      exp_high = (speed < model_cap) ? speed : model_cap;
      measure_period(hl, hr);
      check("motor_l_high", hl, exp_high);
      check("motor_r_high", hr, exp_high);
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial begin
      logic [31:0] r;
      logic [11:0] w;
      logic [3:0]  dur;
      int          n;
      int          exp_cycles;
      int          got_adj;
      int          hl;
      int          hr;
      int          exp_errors;
      clk100_mhz = 1'b0;
      arst_n     = 1'b0;
      ir_in      = 1'b1;
      errors     = 0;
      timeouts   = 0;
      rng        = 32'he0a1;
      model_cap  = 5'd31;
      exp_last   = '0;
      exp_errors = 0;
      repeat (3) tick();
      arst_n = 1'b1;
      tick();
      check("busy", busy, 0);
      check("motor_l", motor_l, 0);
      check("motor_r", motor_r, 0);
      check("frame_errors", frame_errors, 0);

      // Decoding of random words
      repeat (20) begin
         roll(r);
         w = unlike_last(r[11:0], exp_last);
         deliver(w);
      end

      // Duty and direction
      repeat (6) begin
         roll(r);
         dur = 4'(r[14:12]) + 4'd1;
         w   = unlike_last(drive_word(r[0], r[1], r[8:4], dur), exp_last);
         deliver(w);
         wait_period_start();
         check_duty(w[8:4]);
         check("dir_l", dir_l, w[10]);
         check("dir_r", dir_r, w[9]);
      end

      // Timed drives
      repeat (3) begin
         roll(r);
         dur = 4'(r[1:0]) + 4'd1;
         w   = unlike_last(drive_word(r[2], r[3], r[8:4] | 5'd1, dur), exp_last);
         deliver(w);
         wait_period_start();
         check("busy", busy, 1);
         exp_cycles = int'(dur) * `DUR_STEP * PER;
         n = 0;
         while (busy && (n < exp_cycles + 2 * PER)) begin
            n++;
            tick();
         end
         if (busy) begin
            note_timeout("busy to fall");
         end
         // One period of slack either way
         got_adj = ((n >= exp_cycles - PER) && (n <= exp_cycles + PER)) ? exp_cycles : n;
         check("busy_cycles", got_adj, exp_cycles);
         measure_period(hl, hr);
         check("motor_l_high", hl, 0);
         check("motor_r_high", hr, 0);
      end

      // Speed cap then open ended drives
      roll(r);
      deliver(unlike_last(cfg_word(CFG_SPEED_CAP, r[7:0]), exp_last));
      repeat (4) begin
         roll(r);
         w = unlike_last(drive_word(r[0], r[1], r[8:4], 4'd0), exp_last);
         deliver(w);
         wait_period_start();
         check_duty(w[8:4]);
      end

      // Malformed frame while the last open ended drive runs
      check("frame_errors", frame_errors, exp_errors);
      send_bad_frame();
      n = 0;
      while ((frame_errors == 8'(exp_errors)) && (n < 16)) begin
         tick();
         n++;
      end
      if (frame_errors == 8'(exp_errors)) begin
         note_timeout("frame_errors to count");
      end
      exp_errors++;
      check("frame_errors", frame_errors, exp_errors);
      check("last_word", last_word, exp_last);
      check("busy", busy, 1);
      // Receiver recovers on the next good frame, full cap again
      deliver(unlike_last(cfg_word(CFG_SPEED_CAP, 8'd31), exp_last));
      check("frame_errors", frame_errors, exp_errors);

      // Stop during an open ended drive
      roll(r);
      w = unlike_last(drive_word(r[0], r[1], r[8:4] | 5'd1, 4'd0), exp_last);
      deliver(w);
      wait_period_start();
      check("busy", busy, 1);
      deliver(unlike_last(cfg_word(CFG_STOP, r[23:16]), exp_last));
      check("busy", busy, 0);
      wait_period_start();
      measure_period(hl, hr);
      check("motor_l_high", hl, 0);
      check("motor_r_high", hr, 0);
      check("busy", busy, 0);
      check("frame_errors", frame_errors, exp_errors);

      $display("mismatches: %0d, timeouts: %0d", errors, timeouts);
      if ((errors == 0) && (timeouts == 0)) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+.
robot_pkg.sv
ir_receiver.sv
move_controller.sv
motor_pwm.sv
robot_top.sv
tb_robot.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = tb_robot
FILELIST  = src.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = sim failed

.PHONY: sim clean

# Build, run, then fail the target if the log holds the fail message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
